//--- run_sim.sh
#!/bin/sh
# Build and run the reset sequencer testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_reset_sequencer -f src.f &&
./obj_dir/Vtb_reset_sequencer 2>&1 | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

//--- src.f
verilog/reset_seq_pkg.sv
verilog/seq_ctrl_if.sv
verilog/request_capture.sv
verilog/reset_seq_fsm.sv
verilog/reset_step_timer.sv
verilog/reset_pattern_decode.sv
verilog/reset_sequencer_top.sv
testbench/reset_sequencer_sva.sv
testbench/tb_reset_sequencer.sv

//--- testbench/reset_sequencer_sva.sv
// Protocol assertions on the sequencer outputs, bound into the top level
`default_nettype none

module reset_sequencer_sva (
    input logic clk,
    input logic rst_n,
    input logic core_rst,
    input logic periph_rst,
    input logic mem_rst,
    input logic io_rst,
    input logic sequence_done
);

    // Done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sequence_done |=> !sequence_done)
        else $error("sequence_done held for more than one cycle");

    // All domains released when done fires
    a_done_released: assert property (@(posedge clk) disable iff (!rst_n)
        sequence_done |-> ({core_rst, periph_rst, mem_rst, io_rst} == 4'b0000))
        else $error("domain reset still active with sequence_done");

    // Core is released first, so it never holds alone
    a_core_order: assert property (@(posedge clk) disable iff (!rst_n)
        core_rst |-> (periph_rst && mem_rst && io_rst))
        else $error("core_rst active while another domain is released");

endmodule

bind reset_sequencer_top reset_sequencer_sva u_sva (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_rst      (core_rst),
    .periph_rst    (periph_rst),
    .mem_rst       (mem_rst),
    .io_rst        (io_rst),
    .sequence_done (sequence_done)
);

`default_nettype wire

//--- testbench/tb_reset_sequencer.sv
// Random-stimulus testbench for the reset sequencer; a cycle model in
// the bench predicts the four domain resets and sequence_done each clock
`default_nettype none

module tb_reset_sequencer;

    localparam int num_sequences = 41;
    localparam int cycle_limit   = num_sequences * 40 + 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       trigger_reset;
    logic       config_mode;
    logic [1:0] sequence_select;
    logic       core_rst;
    logic       periph_rst;
    logic       mem_rst;
    logic       io_rst;
    logic       sequence_done;

    // Model state
    logic       m_trig_prev = 1'b0;
    logic       m_busy      = 1'b0;
    int         m_age       = 0;
    logic [1:0] m_sel       = 2'd0;
    logic       m_long      = 1'b0;
    logic [3:0] exp_mask    = 4'b0000;
    logic       exp_done    = 1'b0;

    int          errors          = 0;
    int          errors_at_start = 0;
    int          tests_run       = 0;
    int          tests_failed    = 0;
    int          cycle_count     = 0;
    int unsigned seed_init;

    reset_sequencer_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .trigger_reset   (trigger_reset),
        .config_mode     (config_mode),
        .sequence_select (sequence_select),
        .core_rst        (core_rst),
        .periph_rst      (periph_rst),
        .mem_rst         (mem_rst),
        .io_rst          (io_rst),
        .sequence_done   (sequence_done)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // Release pattern per step, core/periph/mem/io from high bit down
    function automatic logic [3:0] pattern_mask(input logic [1:0] sel, input int step);
        logic [3:0] mask;
        mask = 4'b1111;
        if (sel == 2'd0) begin
            if (step >= 6) begin
                mask = 4'b0000;
            end else if (step >= 4) begin
                mask = 4'b0011;
            end else if (step >= 2) begin
                mask = 4'b0111;
            end
        end else if (sel == 2'd1) begin
            if (step >= 5) begin
                mask = 4'b0000;
            end else if (step >= 3) begin
                mask = 4'b0101;
            end
        end
        return mask;
    endfunction

    // --------------------------------------------------
    // Cycle model, age counts edges since the start edge
    // --------------------------------------------------
    always @(posedge clk) begin : model
        int   len;
        logic start_now;
        if (!rst_n) begin
            m_trig_prev = 1'b0;
            m_busy      = 1'b0;
            m_age       = 0;
            exp_mask    = 4'b0000;
            exp_done    = 1'b0;
        end else begin
            len         = m_long ? 4 : 1;
            start_now   = trigger_reset && !m_trig_prev && !m_busy;
            m_trig_prev = trigger_reset;
            exp_mask    = 4'b0000;
            exp_done    = 1'b0;
            if (m_busy) begin
                m_age++;
                if (m_age >= 2 && m_age < 2 + 8 * len) begin
                    exp_mask = pattern_mask(m_sel, (m_age - 2) / len);
                end else if (m_age == 2 + 8 * len) begin
                    exp_done = 1'b1;
                    m_busy   = 1'b0;
                end
            end
            if (start_now) begin
                m_busy = 1'b1;
                m_age  = 0;
                m_sel  = sequence_select;
                m_long = config_mode;
            end
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Outputs settle after the rising edge, compare mid-cycle
    always @(negedge clk) begin
        check_bit("core_rst", core_rst, exp_mask[3]);
        check_bit("periph_rst", periph_rst, exp_mask[2]);
        check_bit("mem_rst", mem_rst, exp_mask[1]);
        check_bit("io_rst", io_rst, exp_mask[0]);
        check_bit("sequence_done", sequence_done, exp_done);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic end_test(input string name);
        int fresh;
        fresh = errors - errors_at_start;
        tests_run++;
        if (fresh > 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, fresh);
        errors_at_start = errors;
    endtask

    // One trigger, then wait for sequence_done; disturb scrambles the inputs
    // mid-run, hold keeps the trigger high past the end
    task automatic run_sequence(input logic [1:0] sel, input logic mode, input int width,
                                input bit disturb, input bit hold, input int gap);
        int latency;
        int cycles;
        latency         = 3 + 8 * (mode ? 4 : 1);
        cycles          = 0;
        sequence_select = sel;
        config_mode     = mode;
        trigger_reset   = 1'b1;
        while (sequence_done !== 1'b1 && cycles < latency + 20) begin
            next_cycle();
            cycles++;
            if (cycles >= width && !hold) begin
                trigger_reset = 1'b0;
            end
            if (disturb && cycles < latency - 4) begin
                sequence_select = 2'($urandom_range(3));
                config_mode     = 1'($urandom_range(1));
                trigger_reset   = 1'($urandom_range(1));
            end
        end
        if (sequence_done !== 1'b1) begin
            $display("ERROR t=%0t: no sequence_done after trigger, select %0d", $time, sel);
            errors++;
        end else if (cycles != latency) begin
            $display("FAIL t=%0t sequence_done latency got %0d expected %0d",
                     $time, cycles, latency);
            errors++;
        end
        if (hold) begin
            repeat (10) next_cycle();
        end
        trigger_reset = 1'b0;
        repeat (gap) next_cycle();
    endtask

    initial begin
        seed_init       = $urandom(32'h917d9c67);
        rst_n           = 1'b0;
        trigger_reset   = 1'b0;
        config_mode     = 1'b0;
        sequence_select = 2'd0;
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;

        repeat (4) next_cycle();
        end_test("idle after reset");

        run_sequence(2'd0, 1'b0, 1, 1'b0, 1'b0, 2);
        end_test("staged release, short steps");

        for (int s = 1; s < 4; s++) begin
            run_sequence(2'(s), 1'b0, 2, 1'b0, 1'b0, 2);
        end
        for (int s = 0; s < 4; s++) begin
            run_sequence(2'(s), 1'b1, 1, 1'b0, 1'b0, 3);
        end
        end_test("all selections, short and long steps");

        run_sequence(2'd0, 1'b1, 2, 1'b1, 1'b0, 3);
        run_sequence(2'd1, 1'b0, 1, 1'b1, 1'b0, 3);
        run_sequence(2'd2, 1'b0, 1, 1'b0, 1'b1, 2);
        end_test("input changes during a sequence");

        for (int i = 0; i < 30; i++) begin
            run_sequence(2'($urandom_range(3)), 1'($urandom_range(1)),
                         int'($urandom_range(4, 1)), 1'b0, 1'b0,
                         int'($urandom_range(6, 1)));
        end
        end_test("random sequences");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/request_capture.sv
// Samples the trigger, detects its rising edge while idle and latches
// the selection and step mode for the sequence about to start
`default_nettype none

module request_capture (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                trigger_reset,
    input  logic                config_mode,
    input  reset_seq_pkg::sel_t sequence_select,
    input  logic                idle,
    output logic                start,
    output reset_seq_pkg::sel_t sel_latched,
    output logic                long_mode
);

    logic trig_q;
    logic trig_rise;

    // Previous sample low, current sample high
    assign trig_rise = trigger_reset && !trig_q && idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trig_q <= 1'b0;
            start  <= 1'b0;
        end else begin
            trig_q <= trigger_reset;
            start  <= trig_rise;
        end
    end

    // Held for the whole sequence
    always_ff @(posedge clk) begin
        if (trig_rise) begin
            sel_latched <= sequence_select;
            long_mode   <= config_mode;
        end
    end

endmodule

`default_nettype wire

//--- verilog/reset_pattern_decode.sv
// Maps the latched selection and the current step to the four domain
// resets; outputs are registered one cycle behind the FSM
`default_nettype none

module reset_pattern_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  reset_seq_pkg::sel_t sel_latched,
    seq_ctrl_if.decode          ctrl,
    output logic                core_rst,
    output logic                periph_rst,
    output logic                mem_rst,
    output logic                io_rst,
    output logic                sequence_done
);

    reset_seq_pkg::rst_mask_t mask_next;
    reset_seq_pkg::rst_mask_t mask_q;
    logic                     done_q;

    // --------------------------------------------------
    // Pattern rule
    // --------------------------------------------------
    always_comb begin
        mask_next = reset_seq_pkg::mask_none;
        if (ctrl.active) begin
            case (sel_latched)
                reset_seq_pkg::sel_staged: begin
                    // Core first, then periph, then mem and io together
                    if (ctrl.step < 3'd2) begin
                        mask_next = reset_seq_pkg::mask_all;
                    end else if (ctrl.step < 3'd4) begin
                        mask_next = reset_seq_pkg::mask_no_core;
                    end else if (ctrl.step < 3'd6) begin
                        mask_next = reset_seq_pkg::mask_mem_io;
                    end
                end
                reset_seq_pkg::sel_split: begin
                    if (ctrl.step < 3'd3) begin
                        mask_next = reset_seq_pkg::mask_all;
                    end else if (ctrl.step < 3'd5) begin
                        mask_next = reset_seq_pkg::mask_split;
                    end
                end
                default: begin
                    mask_next = reset_seq_pkg::mask_all;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask_q <= reset_seq_pkg::mask_none;
            done_q <= 1'b0;
        end else begin
            mask_q <= mask_next;
            done_q <= ctrl.done;
        end
    end

    assign {core_rst, periph_rst, mem_rst, io_rst} = mask_q;
    assign sequence_done = done_q;

endmodule

`default_nettype wire

//--- verilog/reset_seq_fsm.sv
// Sequencer state machine: waits for start, runs the eight steps and
// spends one cycle in DONE before going back to idle
`default_nettype none

module reset_seq_fsm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    output logic       idle,
    seq_ctrl_if.fsm    ctrl
);

    reset_seq_pkg::seq_state_t state;
    reset_seq_pkg::seq_state_t state_next;

    logic last_step_end;

    assign last_step_end = ctrl.step_end && (ctrl.step == reset_seq_pkg::last_step);

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            reset_seq_pkg::IDLE: begin
                if (start) begin
                    state_next = reset_seq_pkg::RUN;
                end
            end
            reset_seq_pkg::RUN: begin
                if (last_step_end) begin
                    state_next = reset_seq_pkg::DONE;
                end
            end
            reset_seq_pkg::DONE: begin
                state_next = reset_seq_pkg::IDLE;
            end
            default: begin
                state_next = reset_seq_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= reset_seq_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    assign idle        = (state == reset_seq_pkg::IDLE);
    assign ctrl.run    = (state == reset_seq_pkg::RUN);
    assign ctrl.active = (state == reset_seq_pkg::RUN);

    // Only one cycle in DONE, so this is a pulse
    assign ctrl.done   = (state == reset_seq_pkg::DONE);

endmodule

`default_nettype wire

//--- verilog/reset_seq_pkg.sv
// Shared widths, step counts, state encoding and release patterns
// for the reset sequencer; referenced by scoped name
`default_nettype none

package reset_seq_pkg;

    // --------------------------------------------------
    // Step timing
    // --------------------------------------------------
    localparam int step_w         = 3;
    localparam int num_steps      = 8;
    localparam int short_step_len = 1;
    localparam int long_step_len  = 4;
    localparam int tick_w         = 2;

    localparam logic [step_w-1:0] last_step      = step_w'(num_steps - 1);
    localparam logic [tick_w-1:0] short_tick_max = tick_w'(short_step_len - 1);
    localparam logic [tick_w-1:0] long_tick_max  = tick_w'(long_step_len - 1);

    // --------------------------------------------------
    // Selection and state
    // --------------------------------------------------
    typedef logic [1:0] sel_t;

    localparam sel_t sel_staged = 2'd0;
    localparam sel_t sel_split  = 2'd1;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } seq_state_t;

    // Domain masks, core/periph/mem/io from high bit down
    typedef logic [3:0] rst_mask_t;

    localparam rst_mask_t mask_all      = 4'b1111;
    localparam rst_mask_t mask_none     = 4'b0000;
    localparam rst_mask_t mask_no_core  = 4'b0111;
    localparam rst_mask_t mask_mem_io   = 4'b0011;
    localparam rst_mask_t mask_split    = 4'b0101;

endpackage

`default_nettype wire

//--- verilog/reset_sequencer_top.sv
// Reset sequencer top level: trigger capture, FSM, step timer and
// pattern decoder behind plain ports
`default_nettype none

module reset_sequencer_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       trigger_reset,
    input  logic       config_mode,
    input  logic [1:0] sequence_select,
    output logic       core_rst,
    output logic       periph_rst,
    output logic       mem_rst,
    output logic       io_rst,
    output logic       sequence_done
);

    logic                start;
    logic                idle;
    logic                long_mode;
    reset_seq_pkg::sel_t sel_latched;

    seq_ctrl_if ctrl ();

    request_capture u_capture (
        .clk             (clk),
        .rst_n           (rst_n),
        .trigger_reset   (trigger_reset),
        .config_mode     (config_mode),
        .sequence_select (sequence_select),
        .idle            (idle),
        .start           (start),
        .sel_latched     (sel_latched),
        .long_mode       (long_mode)
    );

    reset_seq_fsm u_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .idle  (idle),
        .ctrl  (ctrl.fsm)
    );

    reset_step_timer u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .long_mode (long_mode),
        .ctrl      (ctrl.timer)
    );

    reset_pattern_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .sel_latched   (sel_latched),
        .ctrl          (ctrl.decode),
        .core_rst      (core_rst),
        .periph_rst    (periph_rst),
        .mem_rst       (mem_rst),
        .io_rst        (io_rst),
        .sequence_done (sequence_done)
    );

endmodule

`default_nettype wire

//--- verilog/reset_step_timer.sv
// Counts cycles within a step and the step index while the sequence
// runs; a step lasts one cycle, or four in long mode
`default_nettype none

module reset_step_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       long_mode,
    seq_ctrl_if.timer  ctrl
);

    logic [reset_seq_pkg::tick_w-1:0] tick;
    logic [reset_seq_pkg::tick_w-1:0] tick_max;
    logic [reset_seq_pkg::step_w-1:0] step_q;

    assign tick_max = long_mode ? reset_seq_pkg::long_tick_max
                                : reset_seq_pkg::short_tick_max;

    // Last cycle of the current step
    assign ctrl.step_end = ctrl.run && (tick == tick_max);
    assign ctrl.step     = step_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick   <= '0;
            step_q <= '0;
        end else if (!ctrl.run) begin
            tick   <= '0;
            step_q <= '0;
        end else if (ctrl.step_end) begin
            tick   <= '0;
            step_q <= step_q + 1'b1;
        end else begin
            tick   <= tick + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/seq_ctrl_if.sv
// Control bundle between the sequencer FSM, the step timer and the
// pattern decoder
`default_nettype none

interface seq_ctrl_if;

    logic                             run;
    logic                             active;
    logic                             done;
    logic [reset_seq_pkg::step_w-1:0] step;
    logic                             step_end;

    modport fsm (
        output run, active, done,
        input  step, step_end
    );

    modport timer (
        input  run,
        output step, step_end
    );

    modport decode (
        input  active, step, done
    );

endinterface

`default_nettype wire
